// File: addrgen_burst_splitter.sv
`timescale 1ns/100ps
`default_nettype none

module addrgen_burst_splitter import addrgen_pkg::*; #(
  parameter int unsigned AxiDataWidth = 64
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  addrgen_req_if.split  req,
  output logic          ar_valid_o,
  output addr_t         ar_addr_o,
  output axi_len_t      ar_len_o,
  output axi_size_t     ar_size_o,
  output logic          aw_valid_o,
  output addr_t         aw_addr_o,
  output axi_len_t      aw_len_o,
  output axi_size_t     aw_size_o,
  input  wire logic     ar_ready_i,
  input  wire logic     aw_ready_i,
  input  wire logic     core_st_pending_i,
  output logic          push_o,
  output addr_t         push_addr_o,
  output axi_len_t      push_len_o,
  output axi_size_t     push_size_o,
  output logic          push_is_load_o,
  input  wire logic     q_full_i,
  input  wire logic     q_empty_i,
  input  wire logic     q_head_is_load_i
);

  localparam int unsigned BeatBytes = AxiDataWidth / 8;
  localparam int unsigned BeatLog   = $clog2(BeatBytes);
  localparam addr_t       BeatMask  = addr_t'(BeatBytes - 1);

  enum logic [1:0] {IDLE, SETUP, REQUESTING} state_q, state_d;

  addr_t cur_addr_q, cur_addr_d;
  vl_t   rem_len_q, rem_len_d;
  addr_t win_end_q, win_end_d;
  logic  hold_q;

  //////////////////////////////////////////////////////////////////////
  // Burst window
  //////////////////////////////////////////////////////////////////////

  // Last byte of a burst from addr within beat limit, data end and page end
  function automatic addr_t window_end(addr_t addr, vl_t len, vew_e vew);
    addr_t base;
    addr_t data_end;
    addr_t beat_end;
    addr_t page_end;
    addr_t win;
    base     = addr & ~BeatMask;
    data_end = (addr + (addr_t'(len) << vew) - addr_t'(1)) | BeatMask;
    beat_end = base + addr_t'(MaxBurstBeats * BeatBytes) - addr_t'(1);
    page_end = {base[AddrWidth-1:PageOffsetBits], {PageOffsetBits{1'b1}}};
    win      = beat_end;
    if (data_end < win) win = data_end;
    if (page_end < win) win = page_end;
    return win;
  endfunction

  addr_t     start_addr;
  addr_t     burst_span;
  addr_t     step_elems;
  addr_t     next_addr;
  vl_t       next_len;
  addr_t     issue_addr;
  axi_len_t  issue_len;
  axi_size_t issue_size;
  addr_t     issue_end;
  addr_t     calc_addr;
  vl_t       calc_len;
  logic      order_ok;
  logic      ax_valid;
  logic      ax_ready;
  logic      issue;

  // Current request and where the following one starts
  always_comb begin
    start_addr = cur_addr_q & ~BeatMask;
    burst_span = (win_end_q - start_addr) >> BeatLog;
    if (req.is_burst) begin
      issue_addr = start_addr;
      issue_len  = burst_span[AxiLenWidth-1:0];
      issue_size = axi_size_t'(BeatLog);
      step_elems = (win_end_q - cur_addr_q + addr_t'(1)) >> req.vew;
      next_addr  = win_end_q + addr_t'(1);
    end else begin
      // One element per request
      issue_addr = cur_addr_q;
      issue_len  = '0;
      issue_size = axi_size_t'(req.vew);
      step_elems = addr_t'(1);
      next_addr  = cur_addr_q + req.stride;
    end
    if (step_elems >= addr_t'(rem_len_q)) begin
      next_len = '0;
    end else begin
      next_len = rem_len_q - step_elems[VlWidth-1:0];
    end
  end

  assign issue_end = issue_addr + ((addr_t'(issue_len) + addr_t'(1)) << issue_size) - addr_t'(1);

  // One window calculator serves both SETUP and the step after each issue
  assign calc_addr = (state_q == SETUP) ? cur_addr_q : next_addr;
  assign calc_len  = (state_q == SETUP) ? rem_len_q : next_len;

  //////////////////////////////////////////////////////////////////////
  // Issue and ordering
  //////////////////////////////////////////////////////////////////////

  // Queue may only hold one kind of request at a time
  assign order_ok = q_empty_i || (q_head_is_load_i == req.is_load);

  // Once shown, a request stays valid until the slave takes it
  assign ax_valid = (state_q == REQUESTING) &&
                    (hold_q || (!q_full_i && !core_st_pending_i && order_ok));
  assign ax_ready = req.is_load ? ar_ready_i : aw_ready_i;
  assign issue    = ax_valid && ax_ready;

  assign ar_valid_o = ax_valid && req.is_load;
  assign ar_addr_o  = issue_addr;
  assign ar_len_o   = issue_len;
  assign ar_size_o  = issue_size;
  assign aw_valid_o = ax_valid && !req.is_load;
  assign aw_addr_o  = issue_addr;
  assign aw_len_o   = issue_len;
  assign aw_size_o  = issue_size;

  assign push_o         = issue;
  assign push_addr_o    = issue_addr;
  assign push_len_o     = issue_len;
  assign push_size_o    = issue_size;
  assign push_is_load_o = req.is_load;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    cur_addr_d = cur_addr_q;
    rem_len_d  = rem_len_q;
    win_end_d  = win_end_q;
    req.ready  = 1'b0;
    case (state_q)
      IDLE: begin
        if (req.valid) begin
          cur_addr_d = req.addr;
          rem_len_d  = req.len;
          state_d    = SETUP;
        end
      end
      SETUP: begin
        // Empty vector needs no request
        if (rem_len_q == '0) begin
          req.ready = 1'b1;
          state_d   = IDLE;
        end else begin
          win_end_d = window_end(calc_addr, calc_len, req.vew);
          state_d   = REQUESTING;
        end
      end
      REQUESTING: begin
        if (issue) begin
          cur_addr_d = next_addr;
          rem_len_d  = next_len;
          win_end_d  = window_end(calc_addr, calc_len, req.vew);
          if (next_len == '0) begin
            req.ready = 1'b1;
            state_d   = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      hold_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      hold_q  <= ax_valid && !ax_ready;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_addr_q <= cur_addr_d;
    rem_len_q  <= rem_len_d;
    win_end_q  <= win_end_d;
  end

  page_bound_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o |-> issue_addr[AddrWidth-1:PageOffsetBits] == issue_end[AddrWidth-1:PageOffsetBits]);

  // Loads and stores never share the queue
  same_kind_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_o && !q_empty_i |-> push_is_load_o == q_head_is_load_i);

endmodule

`default_nettype wire

// File: addrgen_frontend.sv
`timescale 1ns/100ps
`default_nettype none

module addrgen_frontend import addrgen_pkg::*; (
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    req_valid_i,
  input  wire mem_op_e req_op_i,
  input  wire addr_t   req_addr_i,
  input  wire vl_t     req_vl_i,
  input  wire addr_t   req_stride_i,
  input  wire vew_e    req_vew_i,
  output logic         ack_o,
  output logic         error_o,
  addrgen_req_if.front req
);

  enum logic [1:0] {IDLE, CHECK, ISSUE} state_q, state_d;

  mem_op_e op_q;
  addr_t   addr_q;
  vl_t     vl_q;
  addr_t   stride_q;
  vew_e    vew_q;
  logic    done_q;
  logic    accept;
  logic    misaligned;

  // The instruction is still held during the ack cycle, so do not take it twice
  assign accept     = (state_q == IDLE) && req_valid_i && !done_q;
  assign misaligned = |(addr_q & ((addr_t'(1) << vew_q) - addr_t'(1)));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = CHECK;
      CHECK:   state_d = misaligned ? IDLE : ISSUE;
      ISSUE:   if (req.ready) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= req.valid && req.ready;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= req_op_i;
      addr_q   <= req_addr_i;
      vl_q     <= req_vl_i;
      stride_q <= req_stride_i;
      vew_q    <= req_vew_i;
    end
  end

  // Misaligned starts are answered straight from CHECK
  assign ack_o   = ((state_q == CHECK) && misaligned) || done_q;
  assign error_o = (state_q == CHECK) && misaligned;

  assign req.addr     = addr_q;
  assign req.len      = vl_q;
  assign req.stride   = stride_q;
  assign req.vew      = vew_q;
  assign req.is_load  = op_q inside {VLE, VLSE};
  assign req.is_burst = op_q inside {VLE, VSE};
  assign req.valid    = ((state_q == CHECK) && !misaligned) || (state_q == ISSUE);

  ack_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_o |=> !ack_o);

endmodule

`default_nettype wire

// File: addrgen_lsu_queue.sv
`timescale 1ns/100ps
`default_nettype none

module addrgen_lsu_queue import addrgen_pkg::*; #(
  parameter int unsigned QueueDepth = 4
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       push_i,
  input  wire addr_t      push_addr_i,
  input  wire axi_len_t   push_len_i,
  input  wire axi_size_t  push_size_i,
  input  wire logic       push_is_load_i,
  input  wire logic       lsu_req_ready_i,
  output logic            lsu_req_valid_o,
  output addr_t           lsu_addr_o,
  output axi_len_t        lsu_len_o,
  output axi_size_t       lsu_size_o,
  output logic            lsu_is_load_o,
  output logic            full_o,
  output logic            empty_o,
  output logic            head_is_load_o
);

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  addr_t               addr_mem [QueueDepth];
  axi_len_t            len_mem  [QueueDepth];
  axi_size_t           size_mem [QueueDepth];
  logic                load_mem [QueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                pop;

  // Pointer advance with wrap for depths that are not a power of two
  function automatic logic [PtrWidth-1:0] ptr_inc(logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(QueueDepth));
  assign pop     = lsu_req_valid_o && lsu_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q <= count_q + CntWidth'(push_i) - CntWidth'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q] <= push_addr_i;
      len_mem[wr_ptr_q]  <= push_len_i;
      size_mem[wr_ptr_q] <= push_size_i;
      load_mem[wr_ptr_q] <= push_is_load_i;
    end
  end

  // Oldest entry goes to the load/store units
  assign lsu_req_valid_o = !empty_o;
  assign lsu_addr_o      = addr_mem[rd_ptr_q];
  assign lsu_len_o       = len_mem[rd_ptr_q];
  assign lsu_size_o      = size_mem[rd_ptr_q];
  assign lsu_is_load_o   = load_mem[rd_ptr_q];
  assign head_is_load_o  = load_mem[rd_ptr_q];

  no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);

endmodule

`default_nettype wire

// File: addrgen_pkg.sv
`default_nettype none

package addrgen_pkg;

  // Vector memory operations handled by the address generator
  typedef enum logic [1:0] {
    VLE,
    VSE,
    VLSE,
    VSSE
  } mem_op_e;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  localparam int unsigned AddrWidth = 32;
  typedef logic [AddrWidth-1:0] addr_t;

  localparam int unsigned VlWidth = 16;
  typedef logic [VlWidth-1:0] vl_t;

  // 4 KiB pages
  localparam int unsigned PageOffsetBits = 12;

  // AXI burst limits and field widths
  localparam int unsigned MaxBurstBeats = 256;

  localparam int unsigned AxiLenWidth = 8;
  typedef logic [AxiLenWidth-1:0] axi_len_t;

  localparam int unsigned AxiSizeWidth = 3;
  typedef logic [AxiSizeWidth-1:0] axi_size_t;

endpackage

`default_nettype wire

// File: addrgen_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface addrgen_req_if import addrgen_pkg::*; (
  input wire logic clk_i
);

  addr_t addr;
  vl_t   len;
  addr_t stride;
  vew_e  vew;
  logic  is_load;
  logic  is_burst;
  logic  valid;
  logic  ready;

  modport front (output addr, len, stride, vew, is_load, is_burst, valid, input ready);
  modport split (input addr, len, stride, vew, is_load, is_burst, valid, output ready);

  // Request is held unchanged until the splitter has finished with it
  req_stable_a: assert property (@(posedge clk_i)
    valid && !ready |=> valid && $stable(addr) && $stable(len) && $stable(is_load));

endinterface

`default_nettype wire

// File: addrgen_top.sv
`timescale 1ns/100ps
`default_nettype none

module addrgen_top import addrgen_pkg::*; #(
  parameter int unsigned AxiDataWidth = 64,
  parameter int unsigned QueueDepth   = 4
) (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // Instruction port
  input  wire logic      req_valid_i,
  input  wire mem_op_e   req_op_i,
  input  wire addr_t     req_addr_i,
  input  wire vl_t       req_vl_i,
  input  wire addr_t     req_stride_i,
  input  wire vew_e      req_vew_i,
  output logic           ack_o,
  output logic           error_o,
  // AXI read address
  output logic           ar_valid_o,
  output addr_t          ar_addr_o,
  output axi_len_t       ar_len_o,
  output axi_size_t      ar_size_o,
  input  wire logic      ar_ready_i,
  // AXI write address
  output logic           aw_valid_o,
  output addr_t          aw_addr_o,
  output axi_len_t       aw_len_o,
  output axi_size_t      aw_size_o,
  input  wire logic      aw_ready_i,
  // Load/store units
  output logic           lsu_req_valid_o,
  output addr_t          lsu_addr_o,
  output axi_len_t       lsu_len_o,
  output axi_size_t      lsu_size_o,
  output logic           lsu_is_load_o,
  input  wire logic      lsu_req_ready_i,
  input  wire logic      core_st_pending_i
);

  logic      push;
  addr_t     push_addr;
  axi_len_t  push_len;
  axi_size_t push_size;
  logic      push_is_load;
  logic      q_full;
  logic      q_empty;
  logic      q_head_is_load;

  addrgen_req_if req_if (.clk_i(clk_i));

  addrgen_frontend u_frontend (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_vl_i    (req_vl_i),
    .req_stride_i(req_stride_i),
    .req_vew_i   (req_vew_i),
    .ack_o       (ack_o),
    .error_o     (error_o),
    .req         (req_if.front)
  );

  addrgen_burst_splitter #(
    .AxiDataWidth(AxiDataWidth)
  ) u_splitter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req              (req_if.split),
    .ar_valid_o       (ar_valid_o),
    .ar_addr_o        (ar_addr_o),
    .ar_len_o         (ar_len_o),
    .ar_size_o        (ar_size_o),
    .aw_valid_o       (aw_valid_o),
    .aw_addr_o        (aw_addr_o),
    .aw_len_o         (aw_len_o),
    .aw_size_o        (aw_size_o),
    .ar_ready_i       (ar_ready_i),
    .aw_ready_i       (aw_ready_i),
    .core_st_pending_i(core_st_pending_i),
    .push_o           (push),
    .push_addr_o      (push_addr),
    .push_len_o       (push_len),
    .push_size_o      (push_size),
    .push_is_load_o   (push_is_load),
    .q_full_i         (q_full),
    .q_empty_i        (q_empty),
    .q_head_is_load_i (q_head_is_load)
  );

  addrgen_lsu_queue #(
    .QueueDepth(QueueDepth)
  ) u_lsu_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_addr_i    (push_addr),
    .push_len_i     (push_len),
    .push_size_i    (push_size),
    .push_is_load_i (push_is_load),
    .lsu_req_ready_i(lsu_req_ready_i),
    .lsu_req_valid_o(lsu_req_valid_o),
    .lsu_addr_o     (lsu_addr_o),
    .lsu_len_o      (lsu_len_o),
    .lsu_size_o     (lsu_size_o),
    .lsu_is_load_o  (lsu_is_load_o),
    .full_o         (q_full),
    .empty_o        (q_empty),
    .head_is_load_o (q_head_is_load)
  );

endmodule

`default_nettype wire

// File: list.f
addrgen_pkg.sv
addrgen_req_if.sv
addrgen_frontend.sv
addrgen_burst_splitter.sv
addrgen_lsu_queue.sv
addrgen_top.sv
tb_addrgen.sv

// File: tb_addrgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_addrgen import addrgen_pkg::*; ();

  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned QueueDepth   = 4;
  localparam int unsigned Timeout      = 2000;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  mem_op_e   req_op_i;
  addr_t     req_addr_i;
  vl_t       req_vl_i;
  addr_t     req_stride_i;
  vew_e      req_vew_i;
  logic      ack_o;
  logic      error_o;
  logic      ar_valid_o;
  addr_t     ar_addr_o;
  axi_len_t  ar_len_o;
  axi_size_t ar_size_o;
  logic      ar_ready_i;
  logic      aw_valid_o;
  addr_t     aw_addr_o;
  axi_len_t  aw_len_o;
  axi_size_t aw_size_o;
  logic      aw_ready_i;
  logic      lsu_req_valid_o;
  addr_t     lsu_addr_o;
  axi_len_t  lsu_len_o;
  axi_size_t lsu_size_o;
  logic      lsu_is_load_o;
  logic      lsu_req_ready_i;
  logic      core_st_pending_i;

  integer      seed;
  logic [31:0] rnd;
  int          errors;
  int          ack_count;
  logic        lsu_en;
  logic        err;

  // Recorded traffic in issue order
  logic [42:0] ar_log [$];
  logic [42:0] aw_log [$];
  logic [43:0] lsu_log [$];
  logic [42:0] exp_ax [8];

  addrgen_top #(
    .AxiDataWidth(AxiDataWidth),
    .QueueDepth  (QueueDepth)
  ) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Bus and load/store unit models
  //////////////////////////////////////////////////////////////////////

  // Random AXI ready and LSU ready under test control
  always @(posedge clk_i) begin
    #1;
    rnd             = $random(seed);
    ar_ready_i      = rnd[0];
    aw_ready_i      = rnd[1];
    lsu_req_ready_i = lsu_en;
  end

  always @(posedge clk_i) begin
    if (rst_ni && ar_valid_o && ar_ready_i) ar_log.push_back({ar_addr_o, ar_len_o, ar_size_o});
    if (rst_ni && aw_valid_o && aw_ready_i) aw_log.push_back({aw_addr_o, aw_len_o, aw_size_o});
    if (rst_ni && lsu_req_valid_o && lsu_req_ready_i) begin
      lsu_log.push_back({lsu_is_load_o, lsu_addr_o, lsu_len_o, lsu_size_o});
    end
    if (rst_ni && ack_o) ack_count++;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [42:0] pack_ax(addr_t addr, axi_len_t len, axi_size_t size);
    return {addr, len, size};
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic report_and_finish();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    errors++;
    $display("Timeout after %0d cycles while waiting for %s", Timeout, what);
    report_and_finish();
  endtask

  task automatic clear_logs();
    ar_log.delete();
    aw_log.delete();
    lsu_log.delete();
    ack_count = 0;
  endtask

  task automatic start_instr(input mem_op_e op, input addr_t addr, input vl_t vl,
                             input addr_t stride, input vew_e vew);
    @(posedge clk_i);
    #1;
    req_op_i     = op;
    req_addr_i   = addr;
    req_vl_i     = vl;
    req_stride_i = stride;
    req_vew_i    = vew;
    req_valid_i  = 1'b1;
  endtask

  // Instruction stays on the port until the acknowledge is seen
  task automatic wait_ack(output logic ack_err);
    int   n;
    logic got;
    got     = 1'b0;
    ack_err = 1'b0;
    for (n = 0; n < Timeout && !got; n++) begin
      @(posedge clk_i);
      if (ack_o) begin
        got     = 1'b1;
        ack_err = error_o;
      end
    end
    if (!got) begin
      fail_timeout("the instruction acknowledge");
    end else begin
      #1;
      req_valid_i = 1'b0;
    end
  endtask

  task automatic wait_lsu_empty();
    int   n;
    logic done;
    done = 1'b0;
    for (n = 0; n < Timeout && !done; n++) begin
      @(posedge clk_i);
      done = !lsu_req_valid_o;
    end
    if (!done) fail_timeout("the load/store unit queue to drain");
  endtask

  task automatic wait_aw_count(input int count);
    int   n;
    logic done;
    done = 1'b0;
    for (n = 0; n < Timeout && !done; n++) begin
      @(negedge clk_i);
      done = (aw_log.size() >= count);
    end
    if (!done) fail_timeout("AW requests");
  endtask

  // Compare the channel and queue logs against exp_ax
  task automatic check_logs(input logic is_load, input int n);
    int          i;
    int          chan_n;
    logic [42:0] got;
    chan_n = is_load ? ar_log.size() : aw_log.size();
    check_value("ack_o pulse count", ack_count, 1);
    check_value(is_load ? "ar request count" : "aw request count", chan_n, n);
    check_value(is_load ? "aw request count" : "ar request count",
                is_load ? aw_log.size() : ar_log.size(), 0);
    check_value("lsu entry count", lsu_log.size(), n);
    for (i = 0; i < n; i++) begin
      if (i < chan_n) begin
        got = is_load ? ar_log[i] : aw_log[i];
        check_value($sformatf("%s addr/len/size #%0d", is_load ? "ar" : "aw", i),
                    got, exp_ax[i]);
      end
      if (i < lsu_log.size()) begin
        check_value($sformatf("lsu is_load/addr/len/size #%0d", i), lsu_log[i],
                    {is_load, exp_ax[i]});
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_unit_load();
    clear_logs();
    lsu_en = 1'b1;
    start_instr(VLE, 32'h1000, 16'd300, '0, EW32);
    wait_ack(err);
    wait_lsu_empty();
    check_value("error_o", err, 1'b0);
    // 1200 bytes fit in one page and under 256 beats
    exp_ax[0] = pack_ax(32'h1000, 8'd149, 3'd3);
    check_logs(1'b1, 1);
  endtask

  task automatic test_page_split();
    clear_logs();
    lsu_en = 1'b1;
    start_instr(VSE, 32'h1F00, 16'd700, '0, EW64);
    wait_ack(err);
    wait_lsu_empty();
    check_value("error_o", err, 1'b0);
    exp_ax[0] = pack_ax(32'h1F00, 8'd31, 3'd3);
    exp_ax[1] = pack_ax(32'h2000, 8'd255, 3'd3);
    exp_ax[2] = pack_ax(32'h2800, 8'd255, 3'd3);
    // Remaining 156 beats close the transfer
    exp_ax[3] = pack_ax(32'h3000, 8'd155, 3'd3);
    check_logs(1'b0, 4);
  endtask

  task automatic test_strided_load();
    int i;
    clear_logs();
    lsu_en = 1'b1;
    start_instr(VLSE, 32'h3002, 16'd4, 32'h40, EW16);
    wait_ack(err);
    wait_lsu_empty();
    check_value("error_o", err, 1'b0);
    for (i = 0; i < 4; i++) exp_ax[i] = pack_ax(32'h3002 + 32'h40 * i, 8'd0, 3'd1);
    check_logs(1'b1, 4);
  endtask

  task automatic test_misaligned();
    clear_logs();
    lsu_en = 1'b1;
    start_instr(VLE, 32'h1001, 16'd4, '0, EW32);
    wait_ack(err);
    check_value("error_o", err, 1'b1);
    repeat (10) @(negedge clk_i);
    check_value("ack_o pulse count", ack_count, 1);
    check_value("ar request count", ar_log.size(), 0);
    check_value("aw request count", aw_log.size(), 0);
  endtask

  task automatic test_ordering();
    clear_logs();
    lsu_en = 1'b0;
    start_instr(VLE, 32'h4000, 16'd4, '0, EW64);
    wait_ack(err);
    @(posedge clk_i);
    check_value("lsu_req_valid_o", lsu_req_valid_o, 1'b1);
    check_value("lsu_is_load_o", lsu_is_load_o, 1'b1);
    start_instr(VSE, 32'h5000, 16'd4, '0, EW64);
    // Store must wait behind the queued load
    repeat (20) begin
      @(posedge clk_i);
      check_value("aw_valid_o", aw_valid_o, 1'b0);
    end
    lsu_en = 1'b1;
    wait_ack(err);
    wait_lsu_empty();
    check_value("error_o", err, 1'b0);
    check_value("ack_o pulse count", ack_count, 2);
    check_value("ar request count", ar_log.size(), 1);
    check_value("aw request count", aw_log.size(), 1);
    check_value("lsu entry count", lsu_log.size(), 2);
    check_value("ar addr/len/size #0", ar_log[0], pack_ax(32'h4000, 8'd3, 3'd3));
    check_value("aw addr/len/size #0", aw_log[0], pack_ax(32'h5000, 8'd3, 3'd3));
    check_value("lsu is_load/addr/len/size #0", lsu_log[0],
                {1'b1, pack_ax(32'h4000, 8'd3, 3'd3)});
    check_value("lsu is_load/addr/len/size #1", lsu_log[1],
                {1'b0, pack_ax(32'h5000, 8'd3, 3'd3)});
  endtask

  task automatic test_backpressure();
    int i;
    clear_logs();
    lsu_en = 1'b0;
    start_instr(VSSE, 32'h6000, 16'd8, 32'h100, EW32);
    wait_aw_count(4);
    repeat (20) @(negedge clk_i);
    check_value("aw request count with full queue", aw_log.size(), 4);
    lsu_en = 1'b1;
    wait_ack(err);
    wait_lsu_empty();
    check_value("error_o", err, 1'b0);
    for (i = 0; i < 8; i++) exp_ax[i] = pack_ax(32'h6000 + 32'h100 * i, 8'd0, 3'd2);
    check_logs(1'b0, 8);
  endtask

  initial begin
    seed              = 32'ha07f_9ef6;
    errors            = 0;
    ack_count         = 0;
    lsu_en            = 1'b0;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_op_i          = VLE;
    req_addr_i        = '0;
    req_vl_i          = '0;
    req_stride_i      = '0;
    req_vew_i         = EW8;
    ar_ready_i        = 1'b0;
    aw_ready_i        = 1'b0;
    lsu_req_ready_i   = 1'b0;
    core_st_pending_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_unit_load();
    test_page_split();
    test_strided_load();
    test_misaligned();
    test_ordering();
    test_backpressure();
    report_and_finish();
  end

endmodule

`default_nettype wire
